// ==== BackEnd.f ====
rtl/BackEndPkg.sv
rtl/ExecuteUnit.sv
rtl/ExMemReg.sv
rtl/DataMemoryStage.sv
rtl/WritebackStage.sv
rtl/BackEnd.sv
verif/BackEndTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = BackEndTb
FILELIST = BackEnd.f

.PHONY: sim clean

# Build the model, then run it; a $fatal gives a failing exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== rtl/BackEnd.sv ====
`default_nettype none

module BackEnd (
    input  wire logic                   Clock,
    input  wire logic                   rst,
    input  var BackEndPkg::IssueBundle  Issue,
    input  wire logic                   IssueValid,
    output var BackEndPkg::RegWritePort WriteBack
);

    BackEndPkg::ExMemBundle executed;
    BackEndPkg::ExMemBundle memAccess;
    BackEndPkg::MemWbBundle memDone;

    ////////////////////////////////////////////////////////////
    // Execute and EX/MEM
    ////////////////////////////////////////////////////////////

    ExecuteUnit i_ExecuteUnit (
        .Issue      (Issue),
        .IssueValid (IssueValid),
        .Result     (executed)
    );

    ExMemReg i_ExMemReg (
        .Clock    (Clock),
        .rst      (rst),
        .Incoming (executed),
        .Outgoing (memAccess)
    );

    ////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////

    DataMemoryStage i_DataMemoryStage (
        .Clock     (Clock),
        .Access    (memAccess),
        .Completed (memDone)
    );

    WritebackStage i_WritebackStage (
        .Clock     (Clock),
        .rst       (rst),
        .Completed (memDone),
        .WriteBack (WriteBack)
    );

endmodule

`default_nettype wire

// ==== rtl/BackEndPkg.sv ====
`default_nettype none

package BackEndPkg;

    ////////////////////////////////////////////////////////////
    // Memory sizing and writeback constants
    ////////////////////////////////////////////////////////////

    // Number of 32-bit words in the data memory
    localparam int DataMemWords = 256;

    // Word index width
    localparam int DataMemAddrBits = $clog2(DataMemWords);

    // Return address offset past the delay slot
    localparam logic [31:0] LinkOffset = 32'd8;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluAnd  = 4'd2,
        AluOr   = 4'd3,
        AluXor  = 4'd4,
        AluNor  = 4'd5,
        AluSlt  = 4'd6,
        AluSltu = 4'd7,
        AluSll  = 4'd8,
        AluSrl  = 4'd9,
        AluSra  = 4'd10,
        AluLui  = 4'd11
    } AluOp;

    // Access width for loads and stores
    typedef enum logic [1:0] {
        SelWord = 2'd0,
        SelHalf = 2'd1,
        SelByte = 2'd2
    } ByteSel;

    // Writeback source, encoding 3 is unused
    typedef enum logic [1:0] {
        WbAlu  = 2'd0,
        WbMem  = 2'd1,
        WbLink = 2'd2
    } WbSrc;

    ////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////

    // Decoded instruction entering execute
    typedef struct packed {
        AluOp        Op;
        logic [31:0] OperandA;
        logic [31:0] OperandB;
        logic [31:0] StoreData;
        logic [31:0] Pc;
        logic [4:0]  RegDest;
        logic        RegWrite;
        logic        MemRead;
        logic        MemWrite;
        logic        SignedLoad;
        ByteSel      Width;
        WbSrc        Source;
    } IssueBundle;

    typedef struct packed {
        logic [31:0] AluResult;
        logic [31:0] StoreData;
        logic [31:0] Pc;
        logic [4:0]  RegDest;
        logic        RegWrite;
        logic        MemRead;
        logic        MemWrite;
        logic        SignedLoad;
        ByteSel      Width;
        WbSrc        Source;
    } ExMemBundle;

    typedef struct packed {
        logic [31:0] AluResult;
        logic [31:0] LoadData;
        logic [31:0] Pc;
        logic [4:0]  RegDest;
        logic        RegWrite;
        WbSrc        Source;
    } MemWbBundle;

    // Register file write port
    typedef struct packed {
        logic        Enable;
        logic [4:0]  Dest;
        logic [31:0] Data;
    } RegWritePort;

endpackage

`default_nettype wire

// ==== rtl/DataMemoryStage.sv ====
`default_nettype none

module DataMemoryStage (
    input  wire logic                  Clock,
    input  var BackEndPkg::ExMemBundle Access,
    output var BackEndPkg::MemWbBundle Completed
);

    logic [31:0] memArray [BackEndPkg::DataMemWords];

    logic [BackEndPkg::DataMemAddrBits-1:0] wordIndex;
    logic [1:0]  lane;
    logic [3:0]  laneEnable;
    logic [31:0] laneData;
    logic [31:0] readWord;
    logic [31:0] shiftedWord;
    logic [31:0] loadValue;

    assign wordIndex = Access.AluResult[BackEndPkg::DataMemAddrBits+1:2];
    assign lane      = Access.AluResult[1:0];

    ////////////////////////////////////////////////////////////
    // Store path
    ////////////////////////////////////////////////////////////

    // Replicate the store data so every lane sees its bytes
    always_comb begin
        case (Access.Width)
            BackEndPkg::SelHalf: begin
                laneEnable = lane[1] ? 4'b1100 : 4'b0011;
                laneData   = {2{Access.StoreData[15:0]}};
            end
            BackEndPkg::SelByte: begin
                laneEnable = 4'b0001 << lane;
                laneData   = {4{Access.StoreData[7:0]}};
            end
            default: begin
                laneEnable = 4'b1111;
                laneData   = Access.StoreData;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (Access.MemWrite) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEnable[i]) begin
                    memArray[wordIndex][i*8 +: 8] <= laneData[i*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Load path
    ////////////////////////////////////////////////////////////

    assign readWord = memArray[wordIndex];

    // Little endian, lane 0 is the low byte
    assign shiftedWord = readWord >> {lane, 3'b000};

    always_comb begin
        case (Access.Width)
            BackEndPkg::SelHalf: begin
                if (Access.SignedLoad) begin
                    loadValue = {{16{shiftedWord[15]}}, shiftedWord[15:0]};
                end else begin
                    loadValue = {16'd0, shiftedWord[15:0]};
                end
            end
            BackEndPkg::SelByte: begin
                if (Access.SignedLoad) begin
                    loadValue = {{24{shiftedWord[7]}}, shiftedWord[7:0]};
                end else begin
                    loadValue = {24'd0, shiftedWord[7:0]};
                end
            end
            default: begin
                loadValue = readWord;
            end
        endcase
    end

    always_comb begin
        Completed.AluResult = Access.AluResult;
        // Keep load data quiet outside of loads
        Completed.LoadData  = Access.MemRead ? loadValue : 32'd0;
        Completed.Pc        = Access.Pc;
        Completed.RegDest   = Access.RegDest;
        Completed.RegWrite  = Access.RegWrite;
        Completed.Source    = Access.Source;
    end

endmodule

`default_nettype wire

// ==== rtl/ExMemReg.sv ====
`default_nettype none

module ExMemReg (
    input  wire logic                  Clock,
    input  wire logic                  rst,
    input  var BackEndPkg::ExMemBundle Incoming,
    output var BackEndPkg::ExMemBundle Outgoing
);

    // Stage register, no enable since nothing stalls
    always_ff @(posedge Clock) begin
        if (rst) begin
            Outgoing <= '0;
        end else begin
            Outgoing <= Incoming;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control consistency checks
    ////////////////////////////////////////////////////////////

    // A single access per instruction
    noReadWriteOverlap: assert property (
        @(posedge Clock) disable iff (rst)
        !(Outgoing.MemRead && Outgoing.MemWrite)
    ) else $error("EX/MEM bundle has MemRead and MemWrite both set");

    // Load data has to reach the register file
    loadWritesBackMem: assert property (
        @(posedge Clock) disable iff (rst)
        Outgoing.MemRead |-> (Outgoing.Source == BackEndPkg::WbMem)
    ) else $error("EX/MEM load with Source other than WbMem");

    property accessAligned;
        @(posedge Clock) disable iff (rst)
        (Outgoing.MemRead || Outgoing.MemWrite) |->
            ((Outgoing.Width == BackEndPkg::SelWord && Outgoing.AluResult[1:0] == 2'b00) ||
             (Outgoing.Width == BackEndPkg::SelHalf && Outgoing.AluResult[0] == 1'b0) ||
             (Outgoing.Width == BackEndPkg::SelByte));
    endproperty

    accessAlignedCheck: assert property (accessAligned)
        else $error("EX/MEM access address %h misaligned", Outgoing.AluResult);

endmodule

`default_nettype wire

// ==== rtl/ExecuteUnit.sv ====
`default_nettype none

module ExecuteUnit (
    input  var BackEndPkg::IssueBundle Issue,
    input  wire logic                  IssueValid,
    output var BackEndPkg::ExMemBundle Result
);

    logic [4:0]  shiftAmount;
    logic [31:0] aluValue;
    logic        signedLess;
    logic        unsignedLess;

    // Only the low five bits count for shifts
    assign shiftAmount  = Issue.OperandB[4:0];
    assign signedLess   = $signed(Issue.OperandA) < $signed(Issue.OperandB);
    assign unsignedLess = Issue.OperandA < Issue.OperandB;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (Issue.Op)
            BackEndPkg::AluAdd: begin
                aluValue = Issue.OperandA + Issue.OperandB;
            end
            BackEndPkg::AluSub: begin
                aluValue = Issue.OperandA - Issue.OperandB;
            end
            BackEndPkg::AluAnd: begin
                aluValue = Issue.OperandA & Issue.OperandB;
            end
            BackEndPkg::AluOr: begin
                aluValue = Issue.OperandA | Issue.OperandB;
            end
            BackEndPkg::AluXor: begin
                aluValue = Issue.OperandA ^ Issue.OperandB;
            end
            BackEndPkg::AluNor: begin
                aluValue = ~(Issue.OperandA | Issue.OperandB);
            end
            BackEndPkg::AluSlt: begin
                aluValue = {31'd0, signedLess};
            end
            BackEndPkg::AluSltu: begin
                aluValue = {31'd0, unsignedLess};
            end
            BackEndPkg::AluSll: begin
                aluValue = Issue.OperandA << shiftAmount;
            end
            BackEndPkg::AluSrl: begin
                aluValue = Issue.OperandA >> shiftAmount;
            end
            BackEndPkg::AluSra: begin
                aluValue = $unsigned($signed(Issue.OperandA) >>> shiftAmount);
            end
            BackEndPkg::AluLui: begin
                aluValue = Issue.OperandB << 16;
            end
            default: begin
                aluValue = 32'd0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result bundle
    ////////////////////////////////////////////////////////////

    always_comb begin
        Result.AluResult  = aluValue;
        Result.StoreData  = Issue.StoreData;
        Result.Pc         = Issue.Pc;
        Result.RegDest    = Issue.RegDest;
        Result.SignedLoad = Issue.SignedLoad;
        Result.Width      = Issue.Width;
        Result.Source     = Issue.Source;
        // A bubble must not write anything downstream
        Result.RegWrite   = Issue.RegWrite & IssueValid;
        Result.MemRead    = Issue.MemRead & IssueValid;
        Result.MemWrite   = Issue.MemWrite & IssueValid;
    end

endmodule

`default_nettype wire

// ==== rtl/WritebackStage.sv ====
`default_nettype none

module WritebackStage (
    input  wire logic                   Clock,
    input  wire logic                   rst,
    input  var BackEndPkg::MemWbBundle  Completed,
    output var BackEndPkg::RegWritePort WriteBack
);

    BackEndPkg::MemWbBundle stage;

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clock) begin
        if (rst) begin
            stage <= '0;
        end else begin
            stage <= Completed;
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (stage.Source)
            BackEndPkg::WbMem: begin
                WriteBack.Data = stage.LoadData;
            end
            BackEndPkg::WbLink: begin
                WriteBack.Data = stage.Pc + BackEndPkg::LinkOffset;
            end
            default: begin
                WriteBack.Data = stage.AluResult;
            end
        endcase
    end

    // Register 0 is hardwired to zero
    assign WriteBack.Enable = stage.RegWrite && (stage.RegDest != 5'd0);
    assign WriteBack.Dest   = stage.RegDest;

    sourceEncodingValid: assert property (
        @(posedge Clock) disable iff (rst)
        stage.Source inside {BackEndPkg::WbAlu, BackEndPkg::WbMem, BackEndPkg::WbLink}
    ) else $error("MEM/WB Source holds unused encoding");

endmodule

`default_nettype wire

// ==== verif/BackEndTb.sv ====
`default_nettype none

module BackEndTb;

    localparam int ClockPeriod = 8;
    localparam int DriveDelay  = 1;
    localparam int ResetCycles = 10;

    typedef struct packed {
        BackEndPkg::IssueBundle  Issue;
        logic                    Valid;
        BackEndPkg::RegWritePort Expect;
    } TableEntry;

    logic                    Clock;
    logic                    rst;
    BackEndPkg::IssueBundle  Issue;
    logic                    IssueValid;
    BackEndPkg::RegWritePort WriteBack;

    TableEntry vectors[$];
    bit        tableBuilt = 1'b0;

    BackEnd i_BackEnd (
        .Clock      (Clock),
        .rst        (rst),
        .Issue      (Issue),
        .IssueValid (IssueValid),
        .WriteBack  (WriteBack)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    ////////////////////////////////////////////////////////////
    // Table entry builders
    ////////////////////////////////////////////////////////////

    function automatic TableEntry blankEntry();
        TableEntry e;
        e = '0;
        e.Issue.Op     = BackEndPkg::AluAdd;
        e.Issue.Width  = BackEndPkg::SelWord;
        e.Issue.Source = BackEndPkg::WbAlu;
        e.Valid        = 1'b1;
        return e;
    endfunction

    function automatic TableEntry makeAlu(input BackEndPkg::AluOp op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [4:0] dest,
                                          input logic expEnable, input logic [31:0] expData);
        TableEntry e;
        e = blankEntry();
        e.Issue.Op       = op;
        e.Issue.OperandA = a;
        e.Issue.OperandB = b;
        e.Issue.RegDest  = dest;
        e.Issue.RegWrite = 1'b1;
        e.Expect.Enable  = expEnable;
        e.Expect.Dest    = dest;
        e.Expect.Data    = expData;
        return e;
    endfunction

    // Address comes out of the ALU as OperandA plus zero
    function automatic TableEntry makeStore(input BackEndPkg::ByteSel width,
                                            input logic [31:0] addr, input logic [31:0] data);
        TableEntry e;
        e = blankEntry();
        e.Issue.OperandA  = addr;
        e.Issue.StoreData = data;
        e.Issue.MemWrite  = 1'b1;
        e.Issue.Width     = width;
        return e;
    endfunction

    function automatic TableEntry makeLoad(input BackEndPkg::ByteSel width, input logic signedLoad,
                                           input logic [31:0] addr, input logic [4:0] dest,
                                           input logic [31:0] expData);
        TableEntry e;
        e = blankEntry();
        e.Issue.OperandA   = addr;
        e.Issue.MemRead    = 1'b1;
        e.Issue.RegWrite   = 1'b1;
        e.Issue.SignedLoad = signedLoad;
        e.Issue.Width      = width;
        e.Issue.Source     = BackEndPkg::WbMem;
        e.Issue.RegDest    = dest;
        e.Expect.Enable    = 1'b1;
        e.Expect.Dest      = dest;
        e.Expect.Data      = expData;
        return e;
    endfunction

    function automatic TableEntry makeLink(input logic [31:0] pc, input logic [4:0] dest,
                                           input logic [31:0] expData);
        TableEntry e;
        e = makeAlu(BackEndPkg::AluAdd, 32'd0, 32'd0, dest, 1'b1, expData);
        e.Issue.Pc     = pc;
        e.Issue.Source = BackEndPkg::WbLink;
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and expected values
    ////////////////////////////////////////////////////////////

    task automatic buildTable();
        TableEntry bubble;
        vectors.push_back(makeAlu(BackEndPkg::AluAdd, 32'h5, 32'h7, 5'd1, 1'b1, 32'h0000_000C));
        vectors.push_back(makeAlu(BackEndPkg::AluSub, 32'h5, 32'h7, 5'd2, 1'b1, 32'hFFFF_FFFE));
        vectors.push_back(makeAlu(BackEndPkg::AluAnd, 32'hF0F0_1234, 32'h0FF0_FF00, 5'd3, 1'b1,
                                  32'h00F0_1200));
        vectors.push_back(makeAlu(BackEndPkg::AluOr, 32'hF000_000F, 32'h0000_F0F0, 5'd4, 1'b1,
                                  32'hF000_F0FF));
        vectors.push_back(makeAlu(BackEndPkg::AluXor, 32'hAAAA_5555, 32'hFFFF_0000, 5'd5, 1'b1,
                                  32'h5555_5555));
        vectors.push_back(makeAlu(BackEndPkg::AluNor, 32'h0F0F_0000, 32'h00F0_00FF, 5'd6, 1'b1,
                                  32'hF000_FF00));
        // Signed and unsigned compares of -2 against 3 disagree
        vectors.push_back(makeAlu(BackEndPkg::AluSlt, 32'hFFFF_FFFE, 32'h3, 5'd7, 1'b1, 32'h1));
        vectors.push_back(makeAlu(BackEndPkg::AluSltu, 32'hFFFF_FFFE, 32'h3, 5'd8, 1'b1, 32'h0));
        // Shift amount 0x24 keeps only 4
        vectors.push_back(makeAlu(BackEndPkg::AluSll, 32'h3, 32'h24, 5'd9, 1'b1, 32'h30));
        vectors.push_back(makeAlu(BackEndPkg::AluSrl, 32'h8000_0010, 32'h4, 5'd10, 1'b1,
                                  32'h0800_0001));
        vectors.push_back(makeAlu(BackEndPkg::AluSra, 32'h8000_0010, 32'h4, 5'd11, 1'b1,
                                  32'hF800_0001));
        vectors.push_back(makeAlu(BackEndPkg::AluLui, 32'h0, 32'h1234, 5'd12, 1'b1,
                                  32'h1234_0000));

        // Word at 0x40 and then a byte into lane 1
        vectors.push_back(makeStore(BackEndPkg::SelWord, 32'h40, 32'h8899_AABB));
        vectors.push_back(makeLoad(BackEndPkg::SelWord, 1'b0, 32'h40, 5'd13, 32'h8899_AABB));
        vectors.push_back(makeStore(BackEndPkg::SelByte, 32'h41, 32'h0000_0077));
        vectors.push_back(makeLoad(BackEndPkg::SelWord, 1'b0, 32'h40, 5'd14, 32'h8899_77BB));
        vectors.push_back(makeLoad(BackEndPkg::SelHalf, 1'b1, 32'h42, 5'd15, 32'hFFFF_8899));
        vectors.push_back(makeLoad(BackEndPkg::SelHalf, 1'b0, 32'h42, 5'd16, 32'h0000_8899));
        vectors.push_back(makeLoad(BackEndPkg::SelByte, 1'b1, 32'h40, 5'd17, 32'hFFFF_FFBB));
        vectors.push_back(makeLoad(BackEndPkg::SelByte, 1'b0, 32'h43, 5'd18, 32'h0000_0088));

        // Loads right behind their stores
        vectors.push_back(makeStore(BackEndPkg::SelHalf, 32'h80, 32'h1234_F00D));
        vectors.push_back(makeLoad(BackEndPkg::SelHalf, 1'b1, 32'h80, 5'd19, 32'hFFFF_F00D));
        vectors.push_back(makeStore(BackEndPkg::SelByte, 32'h82, 32'h0000_00C3));
        vectors.push_back(makeLoad(BackEndPkg::SelByte, 1'b1, 32'h82, 5'd20, 32'hFFFF_FFC3));

        vectors.push_back(makeLink(32'h0000_1000, 5'd31, 32'h0000_1008));
        vectors.push_back(makeAlu(BackEndPkg::AluAdd, 32'h1, 32'h1, 5'd0, 1'b0, 32'h2));

        // Bubble carrying a store and a register write
        bubble = makeStore(BackEndPkg::SelWord, 32'h40, 32'hDEAD_BEEF);
        bubble.Valid          = 1'b0;
        bubble.Issue.RegWrite = 1'b1;
        bubble.Issue.RegDest  = 5'd21;
        vectors.push_back(bubble);
        vectors.push_back(makeLoad(BackEndPkg::SelWord, 1'b0, 32'h40, 5'd22, 32'h8899_77BB));

        vectors.push_back(makeAlu(BackEndPkg::AluAdd, 32'h7FFF_FFFF, 32'h1, 5'd23, 1'b1,
                                  32'h8000_0000));
        vectors.push_back(makeAlu(BackEndPkg::AluSub, 32'h0, 32'h1, 5'd24, 1'b1, 32'hFFFF_FFFF));
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] expected, input string where);
        $display("ERROR WriteBack.%s got %h expected %h (%s)", field, got, expected, where);
        $display("*** FAILED ***");
        $fatal(1, "Write port mismatch");
    endtask

    task automatic expectIdle(input string where);
        assert (WriteBack.Enable === 1'b0)
            else reportMismatch("Enable", 32'(WriteBack.Enable), 32'h0, where);
    endtask

    // Dest and Data only matter while the port is enabled
    task automatic checkWriteBack(input int idx);
        string where;
        BackEndPkg::RegWritePort exp;
        where = $sformatf("entry %0d", idx);
        exp = vectors[idx].Expect;
        assert (WriteBack.Enable === exp.Enable)
            else reportMismatch("Enable", 32'(WriteBack.Enable), 32'(exp.Enable), where);
        if (exp.Enable) begin
            assert (WriteBack.Dest === exp.Dest)
                else reportMismatch("Dest", 32'(WriteBack.Dest), 32'(exp.Dest), where);
            assert (WriteBack.Data === exp.Data)
                else reportMismatch("Data", WriteBack.Data, exp.Data, where);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        int total;
        rst        = 1'b1;
        Issue      = '0;
        IssueValid = 1'b0;
        buildTable();
        tableBuilt = 1'b1;
        total = vectors.size();

        // A real register write sits on the input throughout reset
        Issue      = vectors[0].Issue;
        IssueValid = 1'b1;

        repeat (ResetCycles) begin
            @(posedge Clock);
            #(DriveDelay);
            expectIdle("reset");
        end
        rst        = 1'b0;
        Issue      = '0;
        IssueValid = 1'b0;

        // Entry i is checked two edges after it is sampled
        for (int i = 0; i < total + 2; i++) begin
            @(posedge Clock);
            #(DriveDelay);
            if (i >= 2) begin
                checkWriteBack(i - 2);
            end else begin
                expectIdle("after reset");
            end
            if (i < total) begin
                Issue      = vectors[i].Issue;
                IssueValid = vectors[i].Valid;
            end else begin
                Issue      = '0;
                IssueValid = 1'b0;
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

    initial begin : watchdog
        wait (tableBuilt);
        #((vectors.size() + 30) * ClockPeriod);
        $display("Timeout: the test sequence did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
